// ==== hw/outrun_macros.svh ====
/*
    Shared widths, SDRAM region offsets and status page numbers
    for the ROM hub and its readers
*/
`ifndef OUTRUN_MACROS_SVH
`define OUTRUN_MACROS_SVH

// SDRAM bank geometry
`define BA_AW       22
`define BA_DW       16

// Reader address widths
`define MAIN_AW     18
`define SUB_AW      17
`define SND_AW      16    // byte address, not word

// Region offsets inside the bank, in words
`define MAIN_BASE   22'h000000
`define SUB_BASE    22'h080000
`define SND_BASE    22'h0C0000

`define CNT_W       8

// Status pages, top three bits of st_addr
`define PAGE_MAIN   3'd0
`define PAGE_SUB    3'd1
`define PAGE_SND    3'd2
`define PAGE_MISC   3'd3
`define PAGE_DLO    3'd5
`define PAGE_DHI    3'd6

`endif

// ==== hw/mem_bus_pkg.sv ====
/*
    Memory bus types: reader identities, requests from the ports
    to the bank sequencer, responses back and the sequencer state
*/
package mem_bus_pkg;

`include "outrun_macros.svh"

    // Reader identity, also the round-robin slot number
    typedef enum logic [1:0] {
        MAIN = 2'd0,
        SUB  = 2'd1,
        SND  = 2'd2
    } client_e;

    // Port to sequencer, held until done
    typedef struct packed {
        logic               valid;
        logic [`BA_AW-1:0]  addr;
    } bank_req_t;

    // Sequencer to port
    typedef struct packed {
        logic               done;   // one cycle, granted port only
        logic               grant;
        logic [`BA_DW-1:0]  data;
    } bank_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT_DATA
    } seq_state_e;

endpackage

// ==== hw/status_pkg.sv ====
/*
    Status readout types: page codes and the two views
    of the debug status address
*/
package status_pkg;

`include "outrun_macros.svh"

    typedef enum logic [2:0] {
        PG_MAIN = `PAGE_MAIN,
        PG_SUB  = `PAGE_SUB,
        PG_SND  = `PAGE_SND,
        PG_MISC = `PAGE_MISC,
        PG_DLO  = `PAGE_DLO,
        PG_DHI  = `PAGE_DHI
    } st_page_e;

    typedef struct packed {
        st_page_e       page;
        logic [4:0]     index;
    } st_flat_t;

    // Misc page splits the low bits differently
    typedef struct packed {
        st_page_e       page;
        logic           spare;
        logic [3:0]     sub;
    } st_misc_t;

    typedef union packed {
        st_flat_t       flat;
        st_misc_t       misc;
    } st_addr_u;

endpackage

// ==== hw/rom_port.sv ====
/*
    ROM port: one reader's cs/ok front end with a one-word cache,
    region offset and optional byte select
*/
`timescale 1ns/1ps
`include "outrun_macros.svh"

module rom_port import mem_bus_pkg::*; #(
    parameter int                ADDR_W    = 18,
    parameter logic [`BA_AW-1:0] BASE      = '0,
    parameter bit                BYTE_WIDE = 1'b0
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                cs,
    input  logic [ADDR_W-1:0]   addr,
    output logic                ok,
    output logic [`BA_DW-1:0]   data,
    output bank_req_t           req,
    input  bank_rsp_t           rsp
);

    localparam int LSB    = BYTE_WIDE ? 1 : 0;
    localparam int WORD_W = ADDR_W - LSB;

    logic [WORD_W-1:0]  word_addr;
    logic [WORD_W-1:0]  cache_addr;
    logic [`BA_DW-1:0]  cache_word;
    logic [`BA_DW-1:0]  fresh_word;
    logic               cache_valid;
    logic               hit;
    logic               req_q;

    // Even byte address sits in the upper half of the word
    function automatic logic [`BA_DW-1:0] lane(input logic [`BA_DW-1:0] w, input logic odd);
        if (!BYTE_WIDE) return w;
        return odd ? {8'h00, w[7:0]} : {8'h00, w[15:8]};
    endfunction

    assign word_addr  = addr[ADDR_W-1:LSB];
    assign hit        = cache_valid && (cache_addr == word_addr);
    assign fresh_word = rsp.done ? rsp.data : cache_word;

    assign req.valid = req_q;
    assign req.addr  = BASE + `BA_AW'(word_addr);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cache_valid <= 1'b0;
            req_q       <= 1'b0;
            ok          <= 1'b0;
        end else begin
            if (rsp.done) cache_valid <= 1'b1;
            // Drops the cycle after done, before the sequencer looks again
            req_q <= cs && !hit && !rsp.done;
            ok    <= cs && (hit || rsp.done);
        end
    end

    always_ff @(posedge clk) begin
        if (rsp.done) begin
            cache_addr <= word_addr;
            cache_word <= rsp.data;
        end
        data <= lane(fresh_word, addr[0]);
    end

    a_req_ok_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(req.valid && ok));

endmodule

// ==== hw/bank_sequencer.sv ====
/*
    Bank sequencer: grants the SDRAM bank to one reader at a time
    in rotating order and runs the rd/ack/dok handshake
*/
`timescale 1ns/1ps
`include "outrun_macros.svh"

module bank_sequencer import mem_bus_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  bank_req_t           req_main,
    input  bank_req_t           req_sub,
    input  bank_req_t           req_snd,
    output bank_rsp_t           rsp_main,
    output bank_rsp_t           rsp_sub,
    output bank_rsp_t           rsp_snd,
    output logic [`BA_AW-1:0]   ba_addr,
    output logic                ba_rd,
    input  logic                ba_ack,
    input  logic                ba_dok,
    input  logic [`BA_DW-1:0]   data_read,
    output logic                done,
    output client_e             done_client,
    output seq_state_e          state,
    output logic [`BA_DW-1:0]   last_word
);

    logic [2:0]         pending;
    client_e            ptr, gnt, pick;
    logic [`BA_AW-1:0]  pick_addr;

    // Slot that is off places after base, wrapping over three readers
    function automatic client_e rr_step(input client_e base, input int off);
        logic [2:0] sum;
        sum = 3'(base) + 3'(off);
        if (sum >= 3'd3) sum = sum - 3'd3;
        return client_e'(sum[1:0]);
    endfunction

    function automatic bank_rsp_t make_rsp(input client_e who, input client_e owner,
                                           input logic fin, input logic busy,
                                           input logic [`BA_DW-1:0] word);
        bank_rsp_t r;
        r.done  = fin && (owner == who);
        r.grant = busy && (owner == who);
        r.data  = word;
        return r;
    endfunction

    assign pending = {req_snd.valid, req_sub.valid, req_main.valid};

    // Nearest pending slot from ptr wins, so scan from the far end
    always_comb begin
        pick = ptr;
        for (int i = 2; i >= 0; i--) begin
            if (pending[rr_step(ptr, i)]) pick = rr_step(ptr, i);
        end
    end

    always_comb begin
        case (pick)
            SUB:     pick_addr = req_sub.addr;
            SND:     pick_addr = req_snd.addr;
            default: pick_addr = req_main.addr;
        endcase
    end

    // Word is on data_read during dok
    assign done        = (state == WAIT_DATA) && ba_dok;
    assign done_client = gnt;
    assign rsp_main    = make_rsp(MAIN, gnt, done, state != IDLE, data_read);
    assign rsp_sub     = make_rsp(SUB, gnt, done, state != IDLE, data_read);
    assign rsp_snd     = make_rsp(SND, gnt, done, state != IDLE, data_read);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            ba_rd     <= 1'b0;
            ba_addr   <= '0;
            ptr       <= MAIN;
            gnt       <= MAIN;
            last_word <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (|pending) begin
                        gnt     <= pick;
                        ba_addr <= pick_addr;
                        ba_rd   <= 1'b1;
                        state   <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (ba_ack) begin
                        ba_rd <= 1'b0;
                        state <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    if (ba_dok) begin
                        last_word <= data_read;
                        ptr       <= rr_step(gnt, 1);
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_rd_until_ack: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(ba_rd) |-> $past(ba_ack));

    a_single_done: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({rsp_snd.done, rsp_sub.done, rsp_main.done}));

endmodule

// ==== hw/access_counters.sv ====
/*
    Access counters: wrapping per-reader transfer counts and
    the reader of the last completed transfer
*/
`timescale 1ns/1ps
`include "outrun_macros.svh"

module access_counters import mem_bus_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                done,
    input  client_e             done_client,
    output logic [`CNT_W-1:0]   cnt_main,
    output logic [`CNT_W-1:0]   cnt_sub,
    output logic [`CNT_W-1:0]   cnt_snd,
    output client_e             last_client
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_main    <= '0;
            cnt_sub     <= '0;
            cnt_snd     <= '0;
            last_client <= MAIN;
        end else if (done) begin
            last_client <= done_client;
            case (done_client)
                MAIN:    cnt_main <= cnt_main + 1'b1;
                SUB:     cnt_sub  <= cnt_sub + 1'b1;
                SND:     cnt_snd  <= cnt_snd + 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// ==== hw/status_dump.sv ====
/*
    Status dump: registered debug byte chosen by the page
    in st_addr, echoing the address on unused pages
*/
`timescale 1ns/1ps
`include "outrun_macros.svh"

module status_dump import mem_bus_pkg::*, status_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  st_addr_u            st_addr,
    input  logic [`CNT_W-1:0]   cnt_main,
    input  logic [`CNT_W-1:0]   cnt_sub,
    input  logic [`CNT_W-1:0]   cnt_snd,
    input  client_e             last_client,
    input  seq_state_e          state,
    input  logic [`BA_DW-1:0]   last_word,
    output logic [7:0]          st_dout
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            st_dout <= '0;
        end else begin
            case (st_addr.flat.page)
                PG_MAIN: st_dout <= cnt_main;
                PG_SUB:  st_dout <= cnt_sub;
                PG_SND:  st_dout <= cnt_snd;
                PG_MISC: begin
                    // Unlisted misc entries hold the last value
                    case (st_addr.misc.sub)
                        4'd0:    st_dout <= {6'd0, last_client};
                        4'd2:    st_dout <= {6'd0, state};
                        default: st_dout <= st_dout;
                    endcase
                end
                PG_DLO:  st_dout <= last_word[7:0];
                PG_DHI:  st_dout <= last_word[15:8];
                default: st_dout <= st_addr;
            endcase
        end
    end

endmodule

// ==== hw/rom_hub.sv ====
/*
    ROM hub: three CPU ROM readers sharing one SDRAM bank,
    plus transfer counters and the debug status readout
*/
`timescale 1ns/1ps
`include "outrun_macros.svh"

module rom_hub import mem_bus_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    // Main CPU
    input  logic                main_cs,
    input  logic [`MAIN_AW-1:0] main_addr,
    output logic                main_ok,
    output logic [`BA_DW-1:0]   main_data,
    // Sub CPU
    input  logic                sub_cs,
    input  logic [`SUB_AW-1:0]  sub_addr,
    output logic                sub_ok,
    output logic [`BA_DW-1:0]   sub_data,
    // Sound CPU
    input  logic                snd_cs,
    input  logic [`SND_AW-1:0]  snd_addr,
    output logic                snd_ok,
    output logic [7:0]          snd_data,
    // SDRAM bank
    output logic [`BA_AW-1:0]   ba_addr,
    output logic                ba_rd,
    input  logic                ba_ack,
    input  logic                ba_dok,
    input  logic [`BA_DW-1:0]   data_read,
    // Status dump
    input  logic [7:0]          st_addr,
    output logic [7:0]          st_dout
);

    bank_req_t          req_main, req_sub, req_snd;
    bank_rsp_t          rsp_main, rsp_sub, rsp_snd;
    logic [`BA_DW-1:0]  snd_word;
    logic               done;
    client_e            done_client, last_client;
    seq_state_e         seq_state;
    logic [`BA_DW-1:0]  last_word;
    logic [`CNT_W-1:0]  cnt_main, cnt_sub, cnt_snd;

    // Sound port returns the byte in the low half
    assign snd_data = snd_word[7:0];

    rom_port #(.ADDR_W(`MAIN_AW), .BASE(`MAIN_BASE), .BYTE_WIDE(1'b0)) u_main (
        .clk(clk), .arst_n(arst_n), .cs(main_cs), .addr(main_addr),
        .ok(main_ok), .data(main_data), .req(req_main), .rsp(rsp_main)
    );

    rom_port #(.ADDR_W(`SUB_AW), .BASE(`SUB_BASE), .BYTE_WIDE(1'b0)) u_sub (
        .clk(clk), .arst_n(arst_n), .cs(sub_cs), .addr(sub_addr),
        .ok(sub_ok), .data(sub_data), .req(req_sub), .rsp(rsp_sub)
    );

    rom_port #(.ADDR_W(`SND_AW), .BASE(`SND_BASE), .BYTE_WIDE(1'b1)) u_snd (
        .clk(clk), .arst_n(arst_n), .cs(snd_cs), .addr(snd_addr),
        .ok(snd_ok), .data(snd_word), .req(req_snd), .rsp(rsp_snd)
    );

    bank_sequencer u_seq (
        .clk(clk), .arst_n(arst_n),
        .req_main(req_main), .req_sub(req_sub), .req_snd(req_snd),
        .rsp_main(rsp_main), .rsp_sub(rsp_sub), .rsp_snd(rsp_snd),
        .ba_addr(ba_addr), .ba_rd(ba_rd), .ba_ack(ba_ack), .ba_dok(ba_dok),
        .data_read(data_read), .done(done), .done_client(done_client),
        .state(seq_state), .last_word(last_word)
    );

    access_counters u_cnt (
        .clk(clk), .arst_n(arst_n), .done(done), .done_client(done_client),
        .cnt_main(cnt_main), .cnt_sub(cnt_sub), .cnt_snd(cnt_snd),
        .last_client(last_client)
    );

    status_dump u_dump (
        .clk(clk), .arst_n(arst_n), .st_addr(st_addr),
        .cnt_main(cnt_main), .cnt_sub(cnt_sub), .cnt_snd(cnt_snd),
        .last_client(last_client), .state(seq_state), .last_word(last_word),
        .st_dout(st_dout)
    );

endmodule

// ==== bench/tb_tasks.svh ====
/*
    Directed tests for the ROM hub, each driving one behavior
    and checking the response against the bank model rule
*/
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Bank word address that a reader address maps to
function automatic logic [`BA_AW-1:0] bank_addr(input int who, input logic [17:0] a);
    case (who)
        0:       return `MAIN_BASE + `BA_AW'(a);
        1:       return `SUB_BASE + `BA_AW'(a[16:0]);
        default: return `SND_BASE + `BA_AW'(a[15:1]);
    endcase
endfunction

function automatic logic [15:0] model_word(input logic [`BA_AW-1:0] ba);
    return ba[15:0] ^ 16'hA5C3;
endfunction

// Sound reader gets the high byte on even addresses
function automatic logic [15:0] expected_data(input int who, input logic [17:0] a);
    logic [15:0] w;
    w = model_word(bank_addr(who, a));
    if (who != 2) return w;
    return a[0] ? {8'h00, w[7:0]} : {8'h00, w[15:8]};
endfunction

// Packed as {ok, data}
function automatic logic [16:0] reader_out(input int who);
    case (who)
        0:       return {main_ok, main_data};
        1:       return {sub_ok, sub_data};
        default: return {snd_ok, 8'h00, snd_data};
    endcase
endfunction

task automatic report_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    errors++;
    $display("[ERROR] %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
endtask

task automatic report_failure(input string msg);
    errors++;
    $display("Failure at %0d ns: %s", $time, msg);
endtask

task automatic drive_reader(input int who, input logic cs, input logic [17:0] a);
    if (who == 0) begin
        main_cs   <= cs;
        main_addr <= a;
    end else if (who == 1) begin
        sub_cs   <= cs;
        sub_addr <= a[16:0];
    end else begin
        snd_cs   <= cs;
        snd_addr <= a[15:0];
    end
endtask

// One cs/ok read; solo reads also check the bank accesses they cause
task automatic rom_read(input int who, input logic [17:0] a, input bit miss, input bit solo);
    int          starts;
    int          waited;
    logic [16:0] resp;
    @(posedge clk);
    starts = rd_starts;
    drive_reader(who, 1'b1, a);
    waited = 0;
    resp   = '0;
    while (!resp[16] && waited < 100) begin
        @(posedge clk);
        waited++;
        resp = reader_out(who);
    end
    drive_reader(who, 1'b0, a);
    if (miss) exp_cnt[who]++;
    checks++;
    if (!resp[16]) begin
        report_failure($sformatf("reader %0d never raised ok for address 0x%0h", who, a));
    end else if (resp[15:0] !== expected_data(who, a)) begin
        report_mismatch(who == 0 ? "main_data" : who == 1 ? "sub_data" : "snd_data",
                        resp[15:0], expected_data(who, a));
    end
    if (solo && miss) begin
        checks++;
        if (rd_starts != starts + 1) begin
            report_failure($sformatf("reader %0d miss did not start one bank access", who));
        end else if (issued[$] !== bank_addr(who, a)) begin
            report_mismatch("ba_addr", issued[$], bank_addr(who, a));
        end
    end
    if (solo && !miss) begin
        checks++;
        if (rd_starts != starts) begin
            report_failure($sformatf("reader %0d cache hit started a bank access", who));
        end
        // ok one cycle after cs, seen on the second sampled edge
        if (resp[16] && waited != 2) begin
            report_failure($sformatf("reader %0d cache hit ok took %0d cycles", who, waited));
        end
    end
endtask

task automatic status_check(input logic [7:0] a, input logic [7:0] want, input string what);
    @(posedge clk);
    st_addr <= a;
    repeat (2) @(posedge clk);
    checks++;
    if (st_dout !== want) report_mismatch(what, st_dout, want);
endtask

task automatic check_reset_state();
    checks++;
    if (main_ok !== 1'b0) report_mismatch("main_ok", main_ok, 0);
    if (sub_ok !== 1'b0) report_mismatch("sub_ok", sub_ok, 0);
    if (snd_ok !== 1'b0) report_mismatch("snd_ok", snd_ok, 0);
    if (ba_rd !== 1'b0) report_mismatch("ba_rd", ba_rd, 0);
    if (st_dout !== 8'h00) report_mismatch("st_dout", st_dout, 0);
endtask

task automatic check_single_reads();
    rom_read(0, 18'h1_2345, 1'b1, 1'b1);
    rom_read(1, 18'h0_BEEF, 1'b1, 1'b1);
endtask

task automatic check_cache_hits();
    rom_read(0, 18'h1_2345, 1'b0, 1'b1);
    rom_read(0, 18'h1_2345, 1'b0, 1'b1);
    rom_read(1, 18'h0_BEEF, 1'b0, 1'b1);
endtask

// Odd byte of the same word comes from the cache
task automatic check_sound_bytes();
    rom_read(2, 18'h0_1234, 1'b1, 1'b1);
    rom_read(2, 18'h0_1235, 1'b0, 1'b1);
    rom_read(2, 18'h0_0F07, 1'b1, 1'b1);
endtask

task automatic check_parallel_reads();
    int          hits;
    logic [17:0] addrs [3];
    addrs = '{18'h2_ABCD, 18'h1_F00F, 18'h0_BEEF};
    fork
        rom_read(0, addrs[0], 1'b1, 1'b0);
        rom_read(1, addrs[1], 1'b1, 1'b0);
        rom_read(2, addrs[2], 1'b1, 1'b0);
    join
    // Each region must appear once among the last three accesses
    for (int who = 0; who < 3; who++) begin
        hits = 0;
        for (int k = issued.size() - 3; k < issued.size(); k++) begin
            if (issued[k] === bank_addr(who, addrs[who])) hits++;
        end
        checks++;
        if (hits != 1) begin
            report_failure($sformatf("reader %0d access seen %0d times on ba_addr", who, hits));
        end
    end
endtask

// The sound read below is the last transfer, so it is the last client
task automatic check_status_pages();
    logic [15:0] w;
    rom_read(2, 18'h0_7770, 1'b1, 1'b1);
    w = model_word(bank_addr(2, 18'h0_7770));
    status_check({`PAGE_MAIN, 5'd0}, 8'(exp_cnt[0]), "st_dout main count");
    status_check({`PAGE_SUB, 5'd0}, 8'(exp_cnt[1]), "st_dout sub count");
    status_check({`PAGE_SND, 5'd0}, 8'(exp_cnt[2]), "st_dout sound count");
    status_check({`PAGE_MISC, 5'd2}, 8'h00, "st_dout sequencer state");
    status_check({`PAGE_MISC, 5'd0}, 8'h02, "st_dout last client");
    status_check({`PAGE_DLO, 5'd0}, w[7:0], "st_dout last word low");
    status_check({`PAGE_DHI, 5'd0}, w[15:8], "st_dout last word high");
    status_check(8'hE5, 8'hE5, "st_dout echo");
endtask

`endif

// ==== bench/tb_rom_hub.sv ====
/*
    Testbench for the ROM hub: clock, reset, SDRAM bank model,
    watchdog and the directed test sequence
*/
`timescale 1ns/1ps
`include "outrun_macros.svh"

module tb_rom_hub;

    localparam int CLK_PERIOD = 100;
    localparam int TEST_COUNT = 6;

    logic                clk = 1'b0;
    logic                arst_n;
    logic                main_cs, sub_cs, snd_cs;
    logic [`MAIN_AW-1:0] main_addr;
    logic [`SUB_AW-1:0]  sub_addr;
    logic [`SND_AW-1:0]  snd_addr;
    logic                main_ok, sub_ok, snd_ok;
    logic [`BA_DW-1:0]   main_data, sub_data;
    logic [7:0]          snd_data;
    logic [`BA_AW-1:0]   ba_addr;
    logic                ba_rd, ba_ack, ba_dok;
    logic [`BA_DW-1:0]   data_read;
    logic [7:0]          st_addr, st_dout;

    // Bookkeeping shared with the test tasks
    int                  errors = 0;
    int                  checks = 0;
    int                  rd_starts = 0;
    int                  exp_cnt [3] = '{0, 0, 0};
    logic                rd_prev = 1'b0;
    logic [`BA_AW-1:0]   issued [$];

    rom_hub uut (
        .clk(clk), .arst_n(arst_n),
        .main_cs(main_cs), .main_addr(main_addr), .main_ok(main_ok), .main_data(main_data),
        .sub_cs(sub_cs), .sub_addr(sub_addr), .sub_ok(sub_ok), .sub_data(sub_data),
        .snd_cs(snd_cs), .snd_addr(snd_addr), .snd_ok(snd_ok), .snd_data(snd_data),
        .ba_addr(ba_addr), .ba_rd(ba_rd), .ba_ack(ba_ack), .ba_dok(ba_dok),
        .data_read(data_read), .st_addr(st_addr), .st_dout(st_dout)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Every bank access starts on a rising ba_rd
    always @(posedge clk) begin
        if (ba_rd && !rd_prev) begin
            rd_starts = rd_starts + 1;
            issued.push_back(ba_addr);
        end
        rd_prev <= ba_rd;
    end

    `include "tb_tasks.svh"

    // SDRAM bank with random ack and data delays
    initial begin : sdram_model
        int ack_dly;
        int dok_dly;
        void'($urandom(32'hddfd9383));
        forever begin
            @(posedge clk);
            if (ba_rd) begin
                ack_dly = 1 + ($urandom % 4);
                repeat (ack_dly - 1) @(posedge clk);
                ba_ack <= 1'b1;
                @(posedge clk);
                ba_ack  <= 1'b0;
                dok_dly = 1 + ($urandom % 6);
                repeat (dok_dly - 1) @(posedge clk);
                ba_dok    <= 1'b1;
                data_read <= ba_addr[15:0] ^ 16'hA5C3;
                @(posedge clk);
                ba_dok <= 1'b0;
            end
        end
    end

    initial begin : test_sequence
        arst_n    = 1'b0;
        main_cs   = 1'b0;
        sub_cs    = 1'b0;
        snd_cs    = 1'b0;
        main_addr = '0;
        sub_addr  = '0;
        snd_addr  = '0;
        ba_ack    = 1'b0;
        ba_dok    = 1'b0;
        data_read = '0;
        st_addr   = '0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        check_reset_state();
        check_single_reads();
        check_cache_hits();
        check_sound_bytes();
        check_parallel_reads();
        check_status_pages();
        repeat (4) @(posedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // 200 cycles per test is far above the slowest bank access pattern
    initial begin : watchdog
        #(TEST_COUNT * 200 * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", TEST_COUNT * 200);
        $display("Checks run: %0d, errors: %0d", checks, errors + 1);
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+hw
+incdir+bench
hw/mem_bus_pkg.sv
hw/status_pkg.sv
hw/rom_port.sv
hw/bank_sequencer.sv
hw/access_counters.sv
hw/status_dump.sv
hw/rom_hub.sv
bench/tb_rom_hub.sv

// ==== Bender.yml ====
package:
  name: rom_hub

sources:
  - include_dirs:
      - hw
    files:
      - hw/mem_bus_pkg.sv
      - hw/status_pkg.sv
      - hw/rom_port.sv
      - hw/bank_sequencer.sv
      - hw/access_counters.sv
      - hw/status_dump.sv
      - hw/rom_hub.sv
  - target: simulation
    include_dirs:
      - hw
      - bench
    files:
      - bench/tb_rom_hub.sv
